// File: common/lotr_params.svh
// address field positions, data RAM geometry and thread count macros
`ifndef LOTR_PARAMS_SVH
`define LOTR_PARAMS_SVH

// ======================================================================
// address map fields
// ======================================================================
// owning core, zero means this core
`define LOTR_CORE_ID_MSB 31
`define LOTR_CORE_ID_LSB 24
// region select inside a core
`define LOTR_REGION_MSB 23
`define LOTR_REGION_LSB 22

// ======================================================================
// data RAM
// ======================================================================
`define LOTR_DMEM_WORDS 1024
// word address, byte address bits 11:2
`define LOTR_DMEM_AW 10

// ======================================================================
// threads
// ======================================================================
`define LOTR_THREADS 4

`endif

// File: common/memMapPkg.sv
// opcode and region enums, core, ring and far request/response structs
`include "lotr_params.svh"
package memMapPkg;

    typedef enum logic {
        RD = 1'b0,
        WR = 1'b1
    } t_opcode;

    // region field of the address, bits 23:22
    typedef enum logic [1:0] {
        REGION_DMEM  = 2'b00,
        REGION_RSVD1 = 2'b01,
        REGION_RSVD2 = 2'b10,
        REGION_CR    = 2'b11
    } t_region;

    // one load or store from the pipeline
    typedef struct packed {
        logic [$clog2(`LOTR_THREADS)-1:0] threadId;
        logic [31:0]                      addr;
        logic [3:0]                       byteEn;
        logic [31:0]                      wrData;
        logic                             rdEn;
        logic                             wrEn;
    } t_coreReq;

    // request from another core
    typedef struct packed {
        logic        valid;
        t_opcode     opcode;
        logic [31:0] addr;
        logic [31:0] data;
    } t_ringReq;

    // our answer to a ring read
    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } t_ringRsp;

    // request this core sends out
    typedef struct packed {
        logic                             valid;
        t_opcode                          opcode;
        logic [$clog2(`LOTR_THREADS)-1:0] threadId;
        logic [31:0]                      addr;
        logic [31:0]                      data;
    } t_farReq;

    // response coming back to this core
    typedef struct packed {
        logic                             valid;
        t_opcode                          opcode;
        logic [$clog2(`LOTR_THREADS)-1:0] threadId;
        logic [31:0]                      data;
    } t_farRsp;

    // decode result per request source
    typedef struct packed {
        logic isLocal;
        logic dmemHit;
        logic crHit;
        logic remote;
    } t_reqHit;

endpackage

// File: common/coreCrPkg.sv
// control-register offset enum and control-output struct
`include "lotr_params.svh"
package coreCrPkg;

    // word offsets inside the CR region
    typedef enum logic [7:0] {
        // read only, returns the strap
        CR_CORE_ID   = 8'h00,
        CR_THREAD_EN = 8'h01,
        CR_SCRATCH0  = 8'h02,
        CR_SCRATCH1  = 8'h03
    } t_crOffset;

    // registers that fan out to the core
    typedef struct packed {
        logic [`LOTR_THREADS-1:0] threadEn;
        logic [31:0]              scratch0;
    } t_coreCr;

endpackage

// File: hdl/memReqDecode.sv
// core and ring request decode into local, region and remote hits
`timescale 1ns/1ps
`include "lotr_params.svh"
module memReqDecode
    import memMapPkg::*;
(
    input  logic [7:0] coreIdStrap,
    input  t_coreReq   coreReq,
    input  t_ringReq   ringReq,
    output t_reqHit    coreHit,
    output t_reqHit    ringHit
);

    logic [7:0] coreIdField;
    t_region    coreRegion;
    t_region    ringRegion;

    // ======================================================================
    // address fields
    // ======================================================================
    assign coreIdField = coreReq.addr[`LOTR_CORE_ID_MSB:`LOTR_CORE_ID_LSB];
    assign coreRegion  = t_region'(coreReq.addr[`LOTR_REGION_MSB:`LOTR_REGION_LSB]);
    // ring requests already carry our core ID, only the region matters
    assign ringRegion  = t_region'(ringReq.addr[`LOTR_REGION_MSB:`LOTR_REGION_LSB]);

    // ======================================================================
    // core side
    // ======================================================================
    always_comb begin
        // zero is the alias for "this core"
        coreHit.isLocal = (coreIdField == 8'd0) || (coreIdField == coreIdStrap);
        coreHit.dmemHit = (coreRegion == REGION_DMEM);
        coreHit.crHit   = (coreRegion == REGION_CR);
        // only a real access goes on the ring
        coreHit.remote  = (coreReq.rdEn || coreReq.wrEn) && !coreHit.isLocal;
    end

    // ======================================================================
    // ring side
    // ======================================================================
    always_comb begin
        ringHit.isLocal = 1'b1;
        ringHit.dmemHit = (ringRegion == REGION_DMEM);
        ringHit.crHit   = (ringRegion == REGION_CR);
        // never forwarded further
        ringHit.remote  = 1'b0;
    end

endmodule

// File: dataMem/dataMem.sv
// dual-port byte-enabled data RAM, core port and ring port
`timescale 1ns/1ps
`include "lotr_params.svh"
module dataMem (
    input  logic                     QClk,
    // core port
    input  logic [`LOTR_DMEM_AW-1:0] coreAddr,
    input  logic [3:0]               coreByteEn,
    input  logic [31:0]              coreWrData,
    input  logic                     coreRdEn,
    input  logic                     coreWrEn,
    output logic [31:0]              coreRdData,
    // ring port, full-word writes
    input  logic [`LOTR_DMEM_AW-1:0] ringAddr,
    input  logic [31:0]              ringWrData,
    input  logic                     ringRdEn,
    input  logic                     ringWrEn,
    output logic [31:0]              ringRdData
);

    logic [31:0] mem [`LOTR_DMEM_WORDS];

    // ======================================================================
    // write and registered read
    // ======================================================================
    always_ff @(posedge QClk) begin
        // ring first, core bytes override on a same-word collision
        if (ringWrEn) begin
            mem[ringAddr] <= ringWrData;
        end
        if (coreWrEn) begin
            for (int b = 0; b < 4; b++) begin
                if (coreByteEn[b]) begin
                    mem[coreAddr][8*b +: 8] <= coreWrData[8*b +: 8];
                end
            end
        end
        // read returns the old word on a same-cycle write
        if (coreRdEn) begin
            coreRdData <= mem[coreAddr];
        end
        if (ringRdEn) begin
            ringRdData <= mem[ringAddr];
        end
    end

endmodule

// File: crFile/crFile.sv
// control-register file with core and ring ports, drives core controls
`timescale 1ns/1ps
`include "lotr_params.svh"
module crFile
    import coreCrPkg::*;
(
    input  logic                     QClk,
    input  logic                     arstN,
    input  logic [7:0]               coreIdStrap,
    // core port
    input  logic [`LOTR_DMEM_AW-1:0] coreAddr,
    input  logic [31:0]              coreWrData,
    input  logic                     coreRdEn,
    input  logic                     coreWrEn,
    output logic [31:0]              coreRdData,
    // ring port
    input  logic [`LOTR_DMEM_AW-1:0] ringAddr,
    input  logic [31:0]              ringWrData,
    input  logic                     ringRdEn,
    input  logic                     ringWrEn,
    output logic [31:0]              ringRdData,
    output t_coreCr                  coreCr
);

    t_coreCr     crQ;
    logic [31:0] scratch1Q;
    t_crOffset   coreOff;
    t_crOffset   ringOff;

    // low 8 bits of the word address pick the register
    assign coreOff = t_crOffset'(coreAddr[7:0]);
    assign ringOff = t_crOffset'(ringAddr[7:0]);

    // read mux shared by both ports
    function automatic logic [31:0] crRead(input t_crOffset off);
        case (off)
            CR_CORE_ID:   crRead = {24'b0, coreIdStrap};
            CR_THREAD_EN: crRead = {{(32-`LOTR_THREADS){1'b0}}, crQ.threadEn};
            CR_SCRATCH0:  crRead = crQ.scratch0;
            CR_SCRATCH1:  crRead = scratch1Q;
            // holes in the map
            default:      crRead = '0;
        endcase
    endfunction

    // ======================================================================
    // register writes
    // ======================================================================
    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            crQ       <= '0;
            scratch1Q <= '0;
        end else begin
            // ring write first, so the core write below wins
            if (ringWrEn) begin
                case (ringOff)
                    CR_THREAD_EN: crQ.threadEn <= ringWrData[`LOTR_THREADS-1:0];
                    CR_SCRATCH0:  crQ.scratch0 <= ringWrData;
                    CR_SCRATCH1:  scratch1Q    <= ringWrData;
                    default:      ;
                endcase
            end
            if (coreWrEn) begin
                case (coreOff)
                    CR_THREAD_EN: crQ.threadEn <= coreWrData[`LOTR_THREADS-1:0];
                    CR_SCRATCH0:  crQ.scratch0 <= coreWrData;
                    CR_SCRATCH1:  scratch1Q    <= coreWrData;
                    // core ID is strap only
                    default:      ;
                endcase
            end
        end
    end

    // one-cycle read, same timing as the RAM
    always_ff @(posedge QClk) begin
        if (coreRdEn) begin
            coreRdData <= crRead(coreOff);
        end
        if (ringRdEn) begin
            ringRdData <= crRead(ringOff);
        end
    end

    assign coreCr = crQ;

endmodule

// File: hdl/farAccessTracker.sv
// far request issue, per-thread wait flags, response hold and replay
`timescale 1ns/1ps
`include "lotr_params.svh"
module farAccessTracker
    import memMapPkg::*;
(
    input  logic                     QClk,
    input  logic                     arstN,
    input  t_coreReq                 coreReq,
    input  logic                     remote,
    output t_farReq                  farReq,
    input  t_farRsp                  farRsp,
    output logic [`LOTR_THREADS-1:0] rcWait,
    output logic                     heldHit,
    output logic [31:0]              heldData
);

    logic [`LOTR_THREADS-1:0] heldQ;
    logic [31:0]              heldDataQ [`LOTR_THREADS];
    logic                     replay;
    logic                     rspRd;

    // thread re-issues its load and the answer is already here
    assign replay = coreReq.rdEn && heldQ[coreReq.threadId];
    // write acks carry nothing to keep
    assign rspRd  = farRsp.valid && (farRsp.opcode == RD);

    // ======================================================================
    // far request, same cycle as the core request
    // ======================================================================
    always_comb begin
        farReq.valid    = remote && !replay;
        farReq.opcode   = coreReq.wrEn ? WR : RD;
        farReq.threadId = coreReq.threadId;
        farReq.addr     = coreReq.addr;
        farReq.data     = coreReq.wrData;
    end

    // ======================================================================
    // per-thread state
    // ======================================================================
    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            rcWait  <= '0;
            heldQ   <= '0;
            heldHit <= 1'b0;
        end else begin
            // lines up with the one-cycle memory reads
            heldHit <= replay;
            for (int t = 0; t < `LOTR_THREADS; t++) begin
                if (replay && (coreReq.threadId == t)) begin
                    heldQ[t] <= 1'b0;
                end
                // response ends the wait and fills the holding register
                if (rspRd && (farRsp.threadId == t)) begin
                    rcWait[t] <= 1'b0;
                    heldQ[t]  <= 1'b1;
                end
                // only remote loads stall the thread
                if (farReq.valid && (farReq.opcode == RD) && (coreReq.threadId == t)) begin
                    rcWait[t] <= 1'b1;
                end
            end
        end
    end

    // response payload and replay data
    always_ff @(posedge QClk) begin
        if (rspRd) begin
            heldDataQ[farRsp.threadId] <= farRsp.data;
        end
        if (replay) begin
            heldData <= heldDataQ[coreReq.threadId];
        end
    end

endmodule

// File: hdl/rspMux.sv
// core read-data select and ring response forming
`timescale 1ns/1ps
module rspMux
    import memMapPkg::*;
(
    input  logic        QClk,
    input  logic        arstN,
    input  logic        coreRdEn,
    input  t_reqHit     coreHit,
    input  logic        ringRdEn,
    input  t_reqHit     ringHit,
    input  logic [31:0] dmemCoreData,
    input  logic [31:0] crCoreData,
    input  logic        heldHit,
    input  logic [31:0] heldData,
    input  logic [31:0] dmemRingData,
    input  logic [31:0] crRingData,
    output logic [31:0] coreRdData,
    output t_ringRsp    ringRsp
);

    logic coreCrSelQ;
    logic coreDmemSelQ;
    logic ringCrSelQ;
    logic ringDmemSelQ;

    // remember the source for next cycle's data
    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            coreCrSelQ   <= 1'b0;
            coreDmemSelQ <= 1'b0;
            ringCrSelQ   <= 1'b0;
            ringDmemSelQ <= 1'b0;
        end else begin
            coreCrSelQ   <= coreRdEn && coreHit.isLocal && coreHit.crHit;
            coreDmemSelQ <= coreRdEn && coreHit.isLocal && coreHit.dmemHit;
            ringCrSelQ   <= ringRdEn && ringHit.isLocal && ringHit.crHit;
            ringDmemSelQ <= ringRdEn && ringHit.isLocal && ringHit.dmemHit;
        end
    end

    // ======================================================================
    // priority: held far data, CR, RAM, zero
    // ======================================================================
    assign coreRdData = heldHit      ? heldData     :
                        coreCrSelQ   ? crCoreData   :
                        coreDmemSelQ ? dmemCoreData :
                                       32'b0;

    // reserved regions give no response
    assign ringRsp.valid = ringCrSelQ || ringDmemSelQ;
    assign ringRsp.data  = ringDmemSelQ ? dmemRingData :
                           ringCrSelQ   ? crRingData   :
                                          32'b0;

endmodule

// File: hdl/dMemWrap.sv
// data-memory top, decode, RAM, CR file, far tracker and response mux
`timescale 1ns/1ps
`include "lotr_params.svh"
module dMemWrap
    import memMapPkg::*;
    import coreCrPkg::*;
(
    input  logic                     QClk,
    input  logic                     arstN,
    input  logic [7:0]               coreIdStrap,
    input  t_coreReq                 coreReq,
    output logic [31:0]              coreRdData,
    output t_coreCr                  coreCr,
    output logic [`LOTR_THREADS-1:0] rcWait,
    input  t_ringReq                 ringReq,
    output t_ringRsp                 ringRsp,
    output t_farReq                  farReq,
    input  t_farRsp                  farRsp
);

    t_reqHit                  coreHit;
    t_reqHit                  ringHit;
    logic [`LOTR_DMEM_AW-1:0] coreWordAddr;
    logic [`LOTR_DMEM_AW-1:0] ringWordAddr;
    logic                     ringRd;
    logic                     ringWr;
    logic [31:0]              dmemCoreData;
    logic [31:0]              dmemRingData;
    logic [31:0]              crCoreData;
    logic [31:0]              crRingData;
    logic                     heldHit;
    logic [31:0]              heldData;

    // ======================================================================
    // strobes
    // ======================================================================
    // byte address to word address
    assign coreWordAddr = coreReq.addr[`LOTR_DMEM_AW+1:2];
    assign ringWordAddr = ringReq.addr[`LOTR_DMEM_AW+1:2];
    assign ringRd       = ringReq.valid && (ringReq.opcode == RD);
    assign ringWr       = ringReq.valid && (ringReq.opcode == WR);

    memReqDecode memReqDecode_inst (
        .coreIdStrap (coreIdStrap),
        .coreReq     (coreReq),
        .ringReq     (ringReq),
        .coreHit     (coreHit),
        .ringHit     (ringHit)
    );

    // ======================================================================
    // local storage
    // ======================================================================
    dataMem dataMem_inst (
        .QClk       (QClk),
        .coreAddr   (coreWordAddr),
        .coreByteEn (coreReq.byteEn),
        .coreWrData (coreReq.wrData),
        .coreRdEn   (coreReq.rdEn && coreHit.isLocal && coreHit.dmemHit),
        .coreWrEn   (coreReq.wrEn && coreHit.isLocal && coreHit.dmemHit),
        .coreRdData (dmemCoreData),
        .ringAddr   (ringWordAddr),
        .ringWrData (ringReq.data),
        .ringRdEn   (ringRd && ringHit.dmemHit),
        .ringWrEn   (ringWr && ringHit.dmemHit),
        .ringRdData (dmemRingData)
    );

    crFile crFile_inst (
        .QClk        (QClk),
        .arstN       (arstN),
        .coreIdStrap (coreIdStrap),
        .coreAddr    (coreWordAddr),
        .coreWrData  (coreReq.wrData),
        .coreRdEn    (coreReq.rdEn && coreHit.isLocal && coreHit.crHit),
        .coreWrEn    (coreReq.wrEn && coreHit.isLocal && coreHit.crHit),
        .coreRdData  (crCoreData),
        .ringAddr    (ringWordAddr),
        .ringWrData  (ringReq.data),
        .ringRdEn    (ringRd && ringHit.crHit),
        .ringWrEn    (ringWr && ringHit.crHit),
        .ringRdData  (crRingData),
        .coreCr      (coreCr)
    );

    // ======================================================================
    // remote path and outputs
    // ======================================================================
    farAccessTracker farAccessTracker_inst (
        .QClk     (QClk),
        .arstN    (arstN),
        .coreReq  (coreReq),
        .remote   (coreHit.remote),
        .farReq   (farReq),
        .farRsp   (farRsp),
        .rcWait   (rcWait),
        .heldHit  (heldHit),
        .heldData (heldData)
    );

    rspMux rspMux_inst (
        .QClk         (QClk),
        .arstN        (arstN),
        .coreRdEn     (coreReq.rdEn),
        .coreHit      (coreHit),
        .ringRdEn     (ringRd),
        .ringHit      (ringHit),
        .dmemCoreData (dmemCoreData),
        .crCoreData   (crCoreData),
        .heldHit      (heldHit),
        .heldData     (heldData),
        .dmemRingData (dmemRingData),
        .crRingData   (crRingData),
        .coreRdData   (coreRdData),
        .ringRsp      (ringRsp)
    );

endmodule

// File: dv/dMemWrapTb.sv
// directed testbench for dMemWrap with shadow RAM model, compare task, tests and cycle timeout
`timescale 1ns/1ps
`include "lotr_params.svh"
module dMemWrapTb
    import memMapPkg::*;
    import coreCrPkg::*;
();

    localparam logic [7:0] myCoreId  = 8'h05;
    localparam logic [7:0] foreignId = 8'h2A;
    // the tests take about 100 cycles
    localparam int         maxCycles = 2000;

    logic                     QClk;
    logic                     arstN;
    logic [7:0]               coreIdStrap;
    t_coreReq                 coreReq;
    logic [31:0]              coreRdData;
    t_coreCr                  coreCr;
    logic [`LOTR_THREADS-1:0] rcWait;
    t_ringReq                 ringReq;
    t_ringRsp                 ringRsp;
    t_farReq                  farReq;
    t_farRsp                  farRsp;

    // reference model of the data RAM
    logic [31:0] shadow [`LOTR_DMEM_WORDS];
    integer      seed;
    int          errCount;
    int          checkCount;
    int          testCount;
    int          cycleCount = 0;

    dMemWrap dMemWrap_inst (
        .QClk        (QClk),
        .arstN       (arstN),
        .coreIdStrap (coreIdStrap),
        .coreReq     (coreReq),
        .coreRdData  (coreRdData),
        .coreCr      (coreCr),
        .rcWait      (rcWait),
        .ringReq     (ringReq),
        .ringRsp     (ringRsp),
        .farReq      (farReq),
        .farRsp      (farRsp)
    );

    initial begin
        QClk = 1'b0;
        forever #5 QClk = ~QClk;
    end

    // ======================================================================
    // helpers
    // ======================================================================
    task automatic checkVal(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            $display("Error %s: expected %h actual %h", name, expected, actual);
            errCount++;
        end
    endtask

    task automatic finishTest(input string name, input int errStart);
        testCount++;
        $display("test %s finished with %0d errors", name, errCount - errStart);
    endtask

    // inputs move 1 ns after the rising edge
    task automatic step();
        @(posedge QClk);
        #1;
    endtask

    // byte address from core id, region and word index
    function automatic logic [31:0] makeAddr(input logic [7:0] id, input t_region region,
                                             input logic [9:0] word);
        makeAddr = {id, region, 10'b0, word, 2'b00};
    endfunction

    function automatic logic [31:0] crAddr(input t_crOffset off);
        crAddr = makeAddr(8'h00, REGION_CR, {2'b00, off});
    endfunction

    // spread test words over the whole index range
    function automatic logic [9:0] wordOf(input int i);
        wordOf = 10'((i * 67 + 3) % `LOTR_DMEM_WORDS);
    endfunction

    task automatic mergeShadow(input logic [9:0] word, input logic [3:0] be,
                               input logic [31:0] data);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                shadow[word][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    task automatic driveCore(input logic rd, input logic wr, input logic [1:0] tid,
                             input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] data);
        coreReq.rdEn     = rd;
        coreReq.wrEn     = wr;
        coreReq.threadId = tid;
        coreReq.addr     = addr;
        coreReq.byteEn   = be;
        coreReq.wrData   = data;
    endtask

    task automatic coreWrite(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] data);
        driveCore(1'b0, 1'b1, 2'd0, addr, be, data);
        step();
        coreReq = '0;
    endtask

    // data is due one cycle after the request
    task automatic coreReadCheck(input string name, input logic [31:0] addr,
                                 input logic [31:0] expected);
        driveCore(1'b1, 1'b0, 2'd0, addr, 4'hf, 32'h0);
        step();
        coreReq = '0;
        checkVal(name, expected, coreRdData);
    endtask

    task automatic ringWrite(input string name, input logic [31:0] addr,
                             input logic [31:0] data);
        ringReq.valid  = 1'b1;
        ringReq.opcode = WR;
        ringReq.addr   = addr;
        ringReq.data   = data;
        step();
        ringReq = '0;
        // writes get no response
        checkVal({name, " rspValid"}, 32'd0, ringRsp.valid);
    endtask

    task automatic ringReadCheck(input string name, input logic [31:0] addr,
                                 input logic [31:0] expected);
        ringReq.valid  = 1'b1;
        ringReq.opcode = RD;
        ringReq.addr   = addr;
        ringReq.data   = 32'h0;
        step();
        ringReq = '0;
        checkVal({name, " rspValid"}, 32'd1, ringRsp.valid);
        checkVal(name, expected, ringRsp.data);
        step();
        // single-cycle pulse
        checkVal({name, " rspValidDrop"}, 32'd0, ringRsp.valid);
    endtask

    task automatic sendFarRsp(input logic [1:0] tid, input logic [31:0] data);
        farRsp.valid    = 1'b1;
        farRsp.opcode   = RD;
        farRsp.threadId = tid;
        farRsp.data     = data;
        step();
        farRsp = '0;
    endtask

    // rcWait falling ends the remote load
    task automatic waitWaitClear(input int t);
        while (rcWait[t] !== 1'b0) begin
            step();
        end
    endtask

    // ======================================================================
    // tests
    // ======================================================================
    task automatic testResetState();
        int errStart;
        errStart = errCount;
        checkVal("reset farValid", 32'd0, farReq.valid);
        checkVal("reset ringValid", 32'd0, ringRsp.valid);
        checkVal("reset rcWait", 32'd0, rcWait);
        checkVal("reset threadEn", 32'd0, coreCr.threadEn);
        finishTest("resetState", errStart);
    endtask

    task automatic testLocalRam();
        int          errStart;
        logic [9:0]  word;
        logic [3:0]  be;
        logic [31:0] data;
        logic [7:0]  id;
        errStart = errCount;
        // full words first since the RAM has no reset value
        for (int i = 0; i < 16; i++) begin
            data = $random(seed);
            coreWrite(makeAddr(8'h00, REGION_DMEM, wordOf(i)), 4'hf, data);
            mergeShadow(wordOf(i), 4'hf, data);
        end
        // random byte merges over both local id aliases
        for (int i = 0; i < 24; i++) begin
            word = wordOf($random(seed) & 15);
            be   = 4'($random(seed));
            data = $random(seed);
            id   = (i % 2 == 1) ? myCoreId : 8'h00;
            coreWrite(makeAddr(id, REGION_DMEM, word), be, data);
            mergeShadow(word, be, data);
        end
        // back-to-back reads give one result per cycle
        for (int i = 0; i < 16; i++) begin
            id = (i % 2 == 1) ? myCoreId : 8'h00;
            driveCore(1'b1, 1'b0, 2'd0, makeAddr(id, REGION_DMEM, wordOf(i)), 4'hf, 32'h0);
            step();
            checkVal("localRam readBack", shadow[wordOf(i)], coreRdData);
        end
        coreReq = '0;
        finishTest("localRam", errStart);
    endtask

    task automatic testCtrlRegs();
        int          errStart;
        logic [31:0] data;
        errStart = errCount;
        coreReadCheck("ctrlRegs coreId", crAddr(CR_CORE_ID), {24'b0, myCoreId});
        // read-only register
        coreWrite(crAddr(CR_CORE_ID), 4'hf, 32'hFFFF_FFFF);
        coreReadCheck("ctrlRegs coreIdRo", crAddr(CR_CORE_ID), {24'b0, myCoreId});
        coreWrite(crAddr(CR_THREAD_EN), 4'hf, 32'h0000_000A);
        data = $random(seed);
        coreWrite(crAddr(CR_SCRATCH0), 4'hf, data);
        checkVal("ctrlRegs threadEnOut", 32'hA, coreCr.threadEn);
        checkVal("ctrlRegs scratch0Out", data, coreCr.scratch0);
        coreReadCheck("ctrlRegs threadEn", crAddr(CR_THREAD_EN), 32'hA);
        coreReadCheck("ctrlRegs scratch0", crAddr(CR_SCRATCH0), data);
        // hole in the CR map
        coreReadCheck("ctrlRegs unknown", makeAddr(8'h00, REGION_CR, 10'h010), 32'h0);
        finishTest("ctrlRegs", errStart);
    endtask

    task automatic testRingAccess();
        int          errStart;
        logic [31:0] data;
        errStart = errCount;
        data = $random(seed);
        ringWrite("ringAccess ramWrite", makeAddr(myCoreId, REGION_DMEM, 10'd100), data);
        shadow[100] = data;
        coreReadCheck("ringAccess ramFromRing", makeAddr(8'h00, REGION_DMEM, 10'd100), data);
        data = $random(seed);
        coreWrite(crAddr(CR_SCRATCH1), 4'hf, data);
        ringReadCheck("ringAccess crFromCore", crAddr(CR_SCRATCH1), data);
        ringReadCheck("ringAccess ramRead", makeAddr(myCoreId, REGION_DMEM, wordOf(2)),
                      shadow[wordOf(2)]);
        finishTest("ringAccess", errStart);
    endtask

    task automatic testRemoteLoad();
        int          errStart;
        logic [31:0] addr;
        logic [31:0] rspData;
        errStart = errCount;
        addr = makeAddr(foreignId, REGION_DMEM, 10'd5);
        driveCore(1'b1, 1'b0, 2'd1, addr, 4'hf, 32'h1234_5678);
        // far request is combinational
        #2;
        checkVal("remoteLoad farValid", 32'd1, farReq.valid);
        checkVal("remoteLoad farOpcode", RD, farReq.opcode);
        checkVal("remoteLoad farThread", 32'd1, farReq.threadId);
        checkVal("remoteLoad farAddr", addr, farReq.addr);
        checkVal("remoteLoad farData", 32'h1234_5678, farReq.data);
        step();
        coreReq = '0;
        checkVal("remoteLoad rcWaitSet", 32'b0010, rcWait);
        repeat (3) step();
        checkVal("remoteLoad rcWaitHold", 32'b0010, rcWait);
        rspData = $random(seed);
        sendFarRsp(2'd1, rspData);
        waitWaitClear(1);
        // replay takes the held data and sends nothing on the ring
        driveCore(1'b1, 1'b0, 2'd1, addr, 4'hf, 32'h0);
        #2;
        checkVal("remoteLoad replayFarValid", 32'd0, farReq.valid);
        step();
        coreReq = '0;
        checkVal("remoteLoad replayData", rspData, coreRdData);
        checkVal("remoteLoad rcWaitAfter", 32'd0, rcWait);
        finishTest("remoteLoad", errStart);
    endtask

    task automatic testIsolation();
        int          errStart;
        logic [31:0] addr;
        logic [31:0] data;
        errStart = errCount;
        // remote store raises no wait
        driveCore(1'b0, 1'b1, 2'd0, makeAddr(foreignId, REGION_DMEM, 10'd7), 4'hf, 32'hCAFE);
        #2;
        checkVal("isolation farWrValid", 32'd1, farReq.valid);
        checkVal("isolation farWrOpcode", WR, farReq.opcode);
        step();
        coreReq = '0;
        checkVal("isolation wrNoWait", 32'd0, rcWait);
        coreReadCheck("isolation rsvdRead", makeAddr(myCoreId, REGION_RSVD1, wordOf(1)), 32'h0);
        data = $random(seed);
        coreWrite(makeAddr(8'h00, REGION_RSVD2, wordOf(0)), 4'hf, data);
        coreReadCheck("isolation rsvdWrite", makeAddr(8'h00, REGION_DMEM, wordOf(0)),
                      shadow[wordOf(0)]);
        // thread 1 waits while thread 2 gets the answer
        addr = makeAddr(foreignId, REGION_DMEM, 10'd9);
        driveCore(1'b1, 1'b0, 2'd1, addr, 4'hf, 32'h0);
        step();
        coreReq = '0;
        data = $random(seed);
        sendFarRsp(2'd2, data);
        checkVal("isolation otherThreadWait", 32'b0010, rcWait);
        driveCore(1'b1, 1'b0, 2'd1, addr, 4'hf, 32'h0);
        #2;
        checkVal("isolation reissueFar", 32'd1, farReq.valid);
        step();
        coreReq = '0;
        checkVal("isolation noReplayData", 32'h0, coreRdData);
        // drain thread 1
        sendFarRsp(2'd1, 32'h0);
        waitWaitClear(1);
        finishTest("isolation", errStart);
    endtask

    // ======================================================================
    // sequence and timeout
    // ======================================================================
    initial begin
        seed        = 34;
        errCount    = 0;
        checkCount  = 0;
        testCount   = 0;
        arstN       = 1'b0;
        coreIdStrap = myCoreId;
        coreReq     = '0;
        ringReq     = '0;
        farRsp      = '0;
        repeat (10) @(posedge QClk);
        #1;
        arstN = 1'b1;
        testResetState();
        testLocalRam();
        testCtrlRegs();
        testRingAccess();
        testRemoteLoad();
        testIsolation();
        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    always @(posedge QClk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            $display("timeout: run did not finish within %0d cycles", maxCycles);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

// File: dMemWrap.f
+incdir+common
common/memMapPkg.sv
common/coreCrPkg.sv
hdl/memReqDecode.sv
dataMem/dataMem.sv
crFile/crFile.sv
hdl/farAccessTracker.sv
hdl/rspMux.sv
hdl/dMemWrap.sv
dv/dMemWrapTb.sv
